// File: Bender.yml
package:
  name: control_unit

sources:
  - rtl/cpu_isa_pkg.sv
  - rtl/uc_ctrl_pkg.sv
  - rtl/instr_decoder.sv
  - rtl/uc_sequencer.sv
  - rtl/ctrl_word_gen.sv
  - rtl/control_unit.sv
  - target: test
    files:
      - verif/tb_control_unit.sv

// File: flist.f
rtl/cpu_isa_pkg.sv
rtl/uc_ctrl_pkg.sv
rtl/instr_decoder.sv
rtl/uc_sequencer.sv
rtl/ctrl_word_gen.sv
rtl/control_unit.sv
verif/tb_control_unit.sv

// File: rtl/control_unit.sv
`timescale 1ns/1ps

module control_unit (
    input  logic                    clk,
    input  logic                    rst,
    input  cpu_isa_pkg::instr_t     ri,
    input  cpu_isa_pkg::ind_t       ind,
    output uc_ctrl_pkg::ctrl_word_t ctrl,
    output uc_ctrl_pkg::uc_state_e  disp_state
);

    uc_ctrl_pkg::decoded_t  next_plan;          // Combinational decode of ri
    uc_ctrl_pkg::decoded_t  plan;               // Latched at DECODE
    uc_ctrl_pkg::uc_state_e state;

    instr_decoder u_decoder (
        .ri        (ri),
        .next_plan (next_plan)
    );

    uc_sequencer u_sequencer (
        .clk       (clk),
        .rst       (rst),
        .next_plan (next_plan),
        .ind       (ind),
        .state     (state),
        .plan      (plan)
    );

    ctrl_word_gen u_ctrl_gen (
        .state     (state),
        .plan      (plan),
        .ind       (ind),
        .ctrl      (ctrl)
    );

    assign disp_state = state;

endmodule

// File: rtl/cpu_isa_pkg.sv
package cpu_isa_pkg;

    localparam int word_w = 16;                 // Instruction and data word

    localparam logic [1:0] mod_ind = 2'b00;     // Register indirect
    localparam logic [1:0] mod_reg = 2'b11;     // Register direct
    localparam logic [2:0] sub_jmp = 3'b101;    // JMP inside CLS_XFER

    ////////////////////////////////////////
    // Instruction word

    typedef enum logic [3:0] {
        CLS_XFER      = 4'b0000,                // Transfers, only JMP kept
        CLS_ONE_OP    = 4'b0001,
        CLS_TWO_OP_NS = 4'b0100,                // CMP/TEST, flags only
        CLS_TWO_OP    = 4'b0101,
        CLS_JCOND     = 4'b1001
    } op_class_e;

    typedef struct packed {
        op_class_e  cls;
        logic [2:0] sub;
        logic       d;                          // 1 = rg is destination
        logic [1:0] mod;
        logic [2:0] rg;
        logic [2:0] rm;
    } instr_t;

    ////////////////////////////////////////
    // Datapath encodings

    typedef enum logic [3:0] {
        ADC  = 4'd0,
        SBB1 = 4'd1,                            // a - b - c
        SBB2 = 4'd2,                            // b - a - c
        NOT  = 4'd3,
        AND  = 4'd4,
        OR   = 4'd5,
        XOR  = 4'd6,
        SHL  = 4'd7,
        SHR  = 4'd8,
        SAR  = 4'd9
    } alu_op_e;

    typedef enum logic [2:0] {
        RA, RB, RC, IS, XA, XB, BA, BB
    } reg_idx_e;

    typedef struct packed {
        logic [word_w-4:0] reserved;
        logic              zero;
        logic              le;
        logic              carry;
    } ind_t;

endpackage

// File: rtl/ctrl_word_gen.sv
`timescale 1ns/1ps

module ctrl_word_gen (
    input  uc_ctrl_pkg::uc_state_e  state,
    input  uc_ctrl_pkg::decoded_t   plan,
    input  cpu_isa_pkg::ind_t       ind,
    output uc_ctrl_pkg::ctrl_word_t ctrl
);

    cpu_isa_pkg::reg_idx_e src_reg;             // Source operand
    cpu_isa_pkg::reg_idx_e dst_reg;             // Destination, also store target
    cpu_isa_pkg::reg_idx_e base_reg;
    cpu_isa_pkg::reg_idx_e index_reg;
    cpu_isa_pkg::reg_idx_e single_reg;          // XA, XB, BA or BB
    cpu_isa_pkg::alu_op_e  exec_op;
    logic                  exec_carry;

    assign src_reg    = cpu_isa_pkg::reg_idx_e'(plan.instr.d ? plan.instr.rm : plan.instr.rg);
    assign dst_reg    = cpu_isa_pkg::reg_idx_e'(plan.instr.d ? plan.instr.rg : plan.instr.rm);
    assign base_reg   = plan.instr.rm[1] ? cpu_isa_pkg::BB : cpu_isa_pkg::BA;
    assign index_reg  = plan.instr.rm[0] ? cpu_isa_pkg::XB : cpu_isa_pkg::XA;
    assign single_reg = cpu_isa_pkg::reg_idx_e'({1'b1, plan.instr.rm[1:0]});

    ////////////////////////////////////////
    // Execute-cycle ALU selection

    always_comb begin
        exec_op    = cpu_isa_pkg::OR;
        exec_carry = 1'b0;
        if (plan.one_op) begin
            case (plan.instr.sub)
                3'b000: {exec_op, exec_carry} = {cpu_isa_pkg::ADC, 1'b1};   // INC
                3'b001: {exec_op, exec_carry} = {cpu_isa_pkg::SBB1, 1'b1};  // DEC
                3'b010: exec_op = cpu_isa_pkg::SBB2;                        // NEG
                3'b011: exec_op = cpu_isa_pkg::NOT;
                3'b100: exec_op = cpu_isa_pkg::SHL;
                3'b101: exec_op = cpu_isa_pkg::SHR;
                default: exec_op = cpu_isa_pkg::SAR;
            endcase
        end else begin
            case (plan.instr.sub)
                3'b000: exec_op = cpu_isa_pkg::ADC;                         // ADD
                3'b001: {exec_op, exec_carry} = {cpu_isa_pkg::ADC, ind.carry};
                3'b010: exec_op = cpu_isa_pkg::SBB1;                        // SUB/CMP
                3'b011: {exec_op, exec_carry} = {cpu_isa_pkg::SBB1, ind.carry};
                3'b100: exec_op = cpu_isa_pkg::AND;                         // AND/TEST
                3'b101: exec_op = cpu_isa_pkg::OR;
                default: exec_op = cpu_isa_pkg::XOR;
            endcase
        end
    end

    ////////////////////////////////////////
    // Per-state transfers

    always_comb begin
        ctrl = '0;
        case (state)
            uc_ctrl_pkg::FETCH0: {ctrl.cp_oe, ctrl.am_we} = 2'b11;     // AM <- CP
            uc_ctrl_pkg::FETCH1,
            uc_ctrl_pkg::LOAD_SRC_MEM1,
            uc_ctrl_pkg::LOAD_DST_MEM1: ctrl.am_oe = 1'b1;              // RAM read at AM
            uc_ctrl_pkg::FETCH2: {ctrl.ram_oe, ctrl.ri_we} = 2'b11;
            uc_ctrl_pkg::ADDR_REG: begin
                ctrl.regs_addr = single_reg;
                ctrl.regs_oe   = 1'b1;
                {ctrl.t2_we, ctrl.t1_we} = {plan.instr.d, !plan.instr.d};
            end
            uc_ctrl_pkg::ADDR_SUM0: begin
                ctrl.regs_addr = base_reg;
                {ctrl.regs_oe, ctrl.t1_we} = 2'b11;
            end
            uc_ctrl_pkg::ADDR_SUM1: begin
                ctrl.regs_addr = index_reg;
                {ctrl.regs_oe, ctrl.t2_we} = 2'b11;
            end
            uc_ctrl_pkg::ADDR_SUM2: begin                               // Base + index
                {ctrl.t1_oe, ctrl.t2_oe, ctrl.alu_oe} = 3'b111;
                ctrl.alu_op = cpu_isa_pkg::ADC;
                {ctrl.t2_we, ctrl.t1_we} = {plan.instr.d, !plan.instr.d};
            end
            uc_ctrl_pkg::LOAD_SRC_REG: begin
                ctrl.regs_addr = src_reg;
                {ctrl.regs_oe, ctrl.t2_we} = 2'b11;
            end
            uc_ctrl_pkg::LOAD_SRC_MEM0: begin                           // AM <- T2
                {ctrl.t2_oe, ctrl.alu_oe, ctrl.am_we} = 3'b111;
                ctrl.alu_op = cpu_isa_pkg::OR;
            end
            uc_ctrl_pkg::LOAD_SRC_MEM2: {ctrl.ram_oe, ctrl.t2_we} = 2'b11;
            uc_ctrl_pkg::LOAD_DST_REG: begin
                ctrl.regs_addr = dst_reg;
                {ctrl.regs_oe, ctrl.t1_we} = 2'b11;
            end
            uc_ctrl_pkg::LOAD_DST_MEM0: begin                           // AM <- T1
                {ctrl.t1_oe, ctrl.alu_oe, ctrl.am_we} = 3'b111;
                ctrl.alu_op = cpu_isa_pkg::OR;
            end
            uc_ctrl_pkg::LOAD_DST_MEM2: {ctrl.ram_oe, ctrl.t1_we} = 2'b11;
            uc_ctrl_pkg::EXEC_1OP,
            uc_ctrl_pkg::EXEC_2OP: begin
                ctrl.t1_oe     = 1'b1;
                ctrl.t2_oe     = (state == uc_ctrl_pkg::EXEC_2OP);
                ctrl.alu_op    = exec_op;
                ctrl.alu_carry = exec_carry;
                {ctrl.alu_oe, ctrl.t1_we, ctrl.ind_sel, ctrl.ind_we} = 4'b1111;
            end
            uc_ctrl_pkg::STORE_REG: begin
                {ctrl.t1_oe, ctrl.alu_oe, ctrl.regs_we} = 3'b111;
                ctrl.alu_op    = cpu_isa_pkg::OR;
                ctrl.regs_addr = dst_reg;
            end
            uc_ctrl_pkg::STORE_MEM0: begin                              // M[AM] <- T1
                {ctrl.t1_oe, ctrl.alu_oe, ctrl.am_oe, ctrl.ram_we} = 4'b1111;
                ctrl.alu_op = cpu_isa_pkg::OR;
            end
            uc_ctrl_pkg::INC_CP0: {ctrl.cp_oe, ctrl.t1_we} = 2'b11;     // T1 <- CP
            uc_ctrl_pkg::INC_CP1: begin                                 // CP <- T1 + 1
                {ctrl.t1_oe, ctrl.alu_oe, ctrl.cp_we} = 3'b111;
                ctrl.alu_op    = cpu_isa_pkg::ADC;
                ctrl.alu_carry = 1'b1;
            end
            uc_ctrl_pkg::JMP: begin                                     // CP <- T1
                {ctrl.t1_oe, ctrl.alu_oe, ctrl.cp_we} = 3'b111;
                ctrl.alu_op = cpu_isa_pkg::OR;
            end
            default: ;                          // RESET, DECODE, STORE_MEM1, JCOND
        endcase
    end

endmodule

// File: rtl/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
    input  cpu_isa_pkg::instr_t   ri,
    output uc_ctrl_pkg::decoded_t next_plan
);

    logic mode_ok;                              // mod 11 or mod 00
    logic kept;                                 // Class and sub-opcode implemented

    // Condition from {sub, d}
    function automatic uc_ctrl_pkg::jcond_e jcond_of(input logic [3:0] code);
        case (code)
            4'b0010: return uc_ctrl_pkg::JC_LE;
            4'b0100: return uc_ctrl_pkg::JC_EQ;
            4'b1100: return uc_ctrl_pkg::JC_NE;
            default: return uc_ctrl_pkg::JC_NONE;
        endcase
    endfunction

    assign mode_ok = (ri.mod == cpu_isa_pkg::mod_reg) || (ri.mod == cpu_isa_pkg::mod_ind);

    always_comb begin
        next_plan       = '0;
        next_plan.instr = ri;

        case (ri.cls)
            cpu_isa_pkg::CLS_XFER: begin
                next_plan.is_jmp  = (ri.sub == cpu_isa_pkg::sub_jmp);
                next_plan.instr.d = 1'b0;       // Target always from rm
            end
            cpu_isa_pkg::CLS_ONE_OP: begin
                next_plan.one_op   = (ri.sub != 3'b111);
                next_plan.store_en = 1'b1;
                next_plan.instr.d  = 1'b0;      // Single operand lives in rm
            end
            cpu_isa_pkg::CLS_TWO_OP_NS: begin
                next_plan.two_op = (ri.sub != 3'b111);
            end
            cpu_isa_pkg::CLS_TWO_OP: begin
                next_plan.two_op   = (ri.sub != 3'b111);
                next_plan.store_en = 1'b1;
            end
            cpu_isa_pkg::CLS_JCOND: begin
                next_plan.jcond = jcond_of({ri.sub, ri.d});
            end
            default: ;
        endcase

        kept = next_plan.one_op || next_plan.two_op || next_plan.is_jmp
            || (next_plan.jcond != uc_ctrl_pkg::JC_NONE);
        next_plan.valid = mode_ok && kept;

        // Indirect with d = 0 writes back through AM
        next_plan.mem_dst = (next_plan.one_op || next_plan.two_op)
            && (ri.mod == cpu_isa_pkg::mod_ind) && !next_plan.instr.d;
    end

endmodule

// File: rtl/uc_ctrl_pkg.sv
package uc_ctrl_pkg;

    localparam int state_w = 6;

    typedef enum logic [state_w-1:0] {
        RESET,
        FETCH0, FETCH1, FETCH2,
        DECODE,
        ADDR_REG, ADDR_SUM0, ADDR_SUM1, ADDR_SUM2,
        LOAD_SRC_REG,
        LOAD_SRC_MEM0, LOAD_SRC_MEM1, LOAD_SRC_MEM2,
        LOAD_DST_REG,
        LOAD_DST_MEM0, LOAD_DST_MEM1, LOAD_DST_MEM2,
        EXEC_1OP, EXEC_2OP,
        STORE_REG, STORE_MEM0, STORE_MEM1,
        INC_CP0, INC_CP1,
        JMP, JCOND
    } uc_state_e;

    ////////////////////////////////////////
    // Control word to the datapath

    typedef struct packed {
        logic                  alu_oe;
        logic                  alu_we;
        logic                  ram_oe;
        logic                  ram_we;
        logic                  io_oe;
        logic                  io_we;
        logic                  regs_oe;
        logic                  regs_we;
        logic                  cp_oe;
        logic                  cp_we;
        logic                  ind_oe;
        logic                  ind_we;
        logic                  am_oe;
        logic                  am_we;
        logic                  aie_oe;
        logic                  aie_we;
        logic                  t1_oe;
        logic                  t1_we;
        logic                  t2_oe;
        logic                  t2_we;
        logic                  ri_oe;
        logic                  ri_we;
        logic                  alu_carry;
        cpu_isa_pkg::alu_op_e  alu_op;
        cpu_isa_pkg::reg_idx_e regs_addr;
        logic                  ind_sel;         // 1 = flags from ALU
    } ctrl_word_t;

    typedef enum logic [1:0] {
        JC_NONE, JC_EQ, JC_NE, JC_LE
    } jcond_e;

    typedef struct packed {
        cpu_isa_pkg::instr_t instr;
        logic                valid;
        logic                one_op;
        logic                two_op;
        logic                store_en;
        logic                mem_dst;           // Result goes back to memory
        logic                is_jmp;
        jcond_e              jcond;
    } decoded_t;

endpackage

// File: rtl/uc_sequencer.sv
`timescale 1ns/1ps

module uc_sequencer (
    input  logic                   clk,
    input  logic                   rst,
    input  uc_ctrl_pkg::decoded_t  next_plan,
    input  cpu_isa_pkg::ind_t      ind,
    output uc_ctrl_pkg::uc_state_e state,
    output uc_ctrl_pkg::decoded_t  plan
);

    uc_ctrl_pkg::uc_state_e state_next;
    logic                   jump_taken;

    ////////////////////////////////////////
    // Phase entry points

    function automatic uc_ctrl_pkg::uc_state_e dst_entry(input uc_ctrl_pkg::decoded_t p);
        return p.mem_dst ? uc_ctrl_pkg::LOAD_DST_MEM0 : uc_ctrl_pkg::LOAD_DST_REG;
    endfunction

    function automatic uc_ctrl_pkg::uc_state_e src_entry(input uc_ctrl_pkg::decoded_t p);
        if (p.two_op && p.instr.mod == cpu_isa_pkg::mod_ind && p.instr.d) begin
            return uc_ctrl_pkg::LOAD_SRC_MEM0;  // Memory source, register dest
        end
        // A one-op memory operand also takes the source slot
        if (p.two_op || p.mem_dst) begin
            return uc_ctrl_pkg::LOAD_SRC_REG;
        end
        return dst_entry(p);
    endfunction

    function automatic uc_ctrl_pkg::uc_state_e exec_entry(input uc_ctrl_pkg::decoded_t p);
        if (p.is_jmp) begin
            return uc_ctrl_pkg::JMP;
        end
        if (p.jcond != uc_ctrl_pkg::JC_NONE) begin
            return uc_ctrl_pkg::JCOND;
        end
        return p.one_op ? uc_ctrl_pkg::EXEC_1OP : uc_ctrl_pkg::EXEC_2OP;
    endfunction

    function automatic uc_ctrl_pkg::uc_state_e store_entry(input uc_ctrl_pkg::decoded_t p);
        if (!p.store_en) begin
            return uc_ctrl_pkg::INC_CP0;        // CMP/TEST keep flags only
        end
        return p.mem_dst ? uc_ctrl_pkg::STORE_MEM0 : uc_ctrl_pkg::STORE_REG;
    endfunction

    // Flag tests follow the datapath's flag polarity
    always_comb begin
        case (plan.jcond)
            uc_ctrl_pkg::JC_EQ: jump_taken = !ind.zero;
            uc_ctrl_pkg::JC_NE: jump_taken = ind.zero;
            uc_ctrl_pkg::JC_LE: jump_taken = !ind.le;
            default:            jump_taken = 1'b0;
        endcase
    end

    ////////////////////////////////////////
    // Next state

    always_comb begin
        state_next = uc_ctrl_pkg::RESET;
        case (state)
            uc_ctrl_pkg::RESET:  state_next = uc_ctrl_pkg::FETCH0;
            uc_ctrl_pkg::FETCH0: state_next = uc_ctrl_pkg::FETCH1;
            uc_ctrl_pkg::FETCH1: state_next = uc_ctrl_pkg::FETCH2;
            uc_ctrl_pkg::FETCH2: state_next = uc_ctrl_pkg::DECODE;
            uc_ctrl_pkg::DECODE: begin
                if (!next_plan.valid) begin
                    state_next = uc_ctrl_pkg::INC_CP0;
                end else if ((next_plan.one_op || next_plan.two_op)
                        && next_plan.instr.mod == cpu_isa_pkg::mod_ind) begin
                    // Top rm bit selects base plus index
                    state_next = next_plan.instr.rm[2] ? uc_ctrl_pkg::ADDR_SUM0
                                                       : uc_ctrl_pkg::ADDR_REG;
                end else begin
                    state_next = src_entry(next_plan);
                end
            end
            uc_ctrl_pkg::ADDR_SUM0:     state_next = uc_ctrl_pkg::ADDR_SUM1;
            uc_ctrl_pkg::ADDR_SUM1:     state_next = uc_ctrl_pkg::ADDR_SUM2;
            uc_ctrl_pkg::ADDR_SUM2,
            uc_ctrl_pkg::ADDR_REG:      state_next = src_entry(plan);
            uc_ctrl_pkg::LOAD_SRC_MEM0: state_next = uc_ctrl_pkg::LOAD_SRC_MEM1;
            uc_ctrl_pkg::LOAD_SRC_MEM1: state_next = uc_ctrl_pkg::LOAD_SRC_MEM2;
            uc_ctrl_pkg::LOAD_SRC_REG,
            uc_ctrl_pkg::LOAD_SRC_MEM2: state_next = dst_entry(plan);
            uc_ctrl_pkg::LOAD_DST_MEM0: state_next = uc_ctrl_pkg::LOAD_DST_MEM1;
            uc_ctrl_pkg::LOAD_DST_MEM1: state_next = uc_ctrl_pkg::LOAD_DST_MEM2;
            uc_ctrl_pkg::LOAD_DST_REG,
            uc_ctrl_pkg::LOAD_DST_MEM2: state_next = exec_entry(plan);
            uc_ctrl_pkg::EXEC_1OP,
            uc_ctrl_pkg::EXEC_2OP:      state_next = store_entry(plan);
            uc_ctrl_pkg::STORE_MEM0:    state_next = uc_ctrl_pkg::STORE_MEM1;
            uc_ctrl_pkg::STORE_REG,
            uc_ctrl_pkg::STORE_MEM1:    state_next = uc_ctrl_pkg::INC_CP0;
            uc_ctrl_pkg::INC_CP0:       state_next = uc_ctrl_pkg::INC_CP1;
            uc_ctrl_pkg::JCOND: begin
                state_next = jump_taken ? uc_ctrl_pkg::JMP : uc_ctrl_pkg::INC_CP0;
            end
            default:                    state_next = uc_ctrl_pkg::FETCH0;  // INC_CP1, JMP
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= uc_ctrl_pkg::RESET;
        end else begin
            state <= state_next;
        end
    end

    // Plan is held until the next decode
    always_ff @(posedge clk) begin
        if (state == uc_ctrl_pkg::DECODE) begin
            plan <= next_plan;
        end
    end

endmodule

// File: verif/control_unit_cases.txt
// ri ind cycles alu_op alu_carry wkind regs_addr   (hex, cycles decimal)
// alu_op f = no execute cycle; wkind 0 none, 1 reg, 2 mem, 3 jump into cp
51CA 0000 10 0 0 1 1   // ADD rb, rc
52C3 0001 10 0 1 1 3   // ADC is, ra with carry set
55F1 0001 10 1 0 1 6   // SUB ba, rb
56D7 0001 10 1 1 1 7   // SBB bb, rc with carry set
59C5 0000 10 4 0 1 0   // AND ra, xb
5ACA 0000 10 5 0 1 2   // OR rc, rb
5DEB 0000 10 6 0 1 5   // XOR xb, is
45C1 0000 9 1 0 0 0    // CMP
48CA 0000 9 4 0 0 0    // TEST
10C2 0000 9 0 1 1 2    // INC rc
12C5 0000 9 1 1 1 5    // DEC xb
14C0 0001 9 2 0 1 0    // NEG ra
16C1 0000 9 3 0 1 1    // NOT rb
18C6 0000 9 7 0 1 6    // SHL ba
1AC7 0000 9 8 0 1 7    // SHR bb
1CC3 0000 9 9 0 1 3    // SAR is
5009 0000 14 0 0 2 0   // ADD [base], rb
5406 0000 16 1 0 2 0   // SUB [base + index], ra
5312 0001 13 0 1 1 2   // ADC rc, [base]
4408 0000 12 1 0 0 0   // CMP [base], rb
1003 0000 14 0 1 2 0   // INC [base]
0AC3 0000 6 f 0 3 0    // JMP
94C1 0000 7 f 0 3 0    // JE taken
94C1 0004 8 f 0 0 0    // JE not taken
9CC1 0004 7 f 0 3 0    // JNE taken
9CC1 0000 8 f 0 0 0    // JNE not taken
92C2 0000 7 f 0 3 0    // JLE taken
92C2 0002 8 f 0 0 0    // JLE not taken
504A 0000 6 f 0 0 0    // ADD with mod 01
1082 0000 6 f 0 0 0    // INC with mod 10
20C1 0000 6 f 0 0 0    // Unused class
00C1 0000 6 f 0 0 0    // MOV, dropped

// File: verif/tb_control_unit.sv
`timescale 1ns/1ps

module tb_control_unit;

    localparam int clk_period   = 20;
    localparam int reset_cycles = 5;
    localparam int case_budget  = 20;           // Cycles allowed per case

    typedef struct packed {
        cpu_isa_pkg::instr_t ri;
        cpu_isa_pkg::ind_t   ind;
        logic [7:0]          cycles;
        logic [3:0]          alu_op;            // 4'hf = no execute cycle
        logic                alu_carry;
        logic [1:0]          wkind;             // 0 none, 1 reg, 2 mem, 3 jump
        logic [2:0]          reg_addr;
    } case_t;

    logic                    clk;
    logic                    rst;
    cpu_isa_pkg::instr_t     ri;
    cpu_isa_pkg::ind_t       ind;
    uc_ctrl_pkg::ctrl_word_t ctrl;
    uc_ctrl_pkg::uc_state_e  disp_state;

    case_t                   cases[$];
    uc_ctrl_pkg::ctrl_word_t trace[$];          // One word per cycle of an instruction
    uc_ctrl_pkg::ctrl_word_t fetch_word;
    logic                    cases_loaded;

    control_unit uut (
        .clk        (clk),
        .rst        (rst),
        .ri         (ri),
        .ind        (ind),
        .ctrl       (ctrl),
        .disp_state (disp_state)
    );

    always #(clk_period / 2) clk = ~clk;

    ////////////////////////////////////////
    // Failure handling and compare tasks

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_ctrl(input string name, input uc_ctrl_pkg::ctrl_word_t exp,
                              input uc_ctrl_pkg::ctrl_word_t act);
        if (act !== exp) begin
            abort_run($sformatf("Error: %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_state(input string name, input uc_ctrl_pkg::uc_state_e exp,
                               input uc_ctrl_pkg::uc_state_e act);
        if (act !== exp) begin
            abort_run($sformatf("Error: %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_alu(input string name, input cpu_isa_pkg::alu_op_e exp_op,
                             input logic exp_carry, input cpu_isa_pkg::alu_op_e act_op,
                             input logic act_carry);
        if (act_op !== exp_op || act_carry !== exp_carry) begin
            abort_run($sformatf("Error: %s alu_op/alu_carry expected %h/%h actual %h/%h",
                name, exp_op, exp_carry, act_op, act_carry));
        end
    endtask

    task automatic check_reg(input string name, input cpu_isa_pkg::reg_idx_e exp,
                             input cpu_isa_pkg::reg_idx_e act);
        if (act !== exp) begin
            abort_run($sformatf("Error: %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            abort_run($sformatf("Error: %s expected %h actual %h", name, exp, act));
        end
    endtask

    ////////////////////////////////////////
    // Case file

    task automatic load_cases();
        int               fd;
        int               n;
        logic [8*160-1:0] line;
        logic [15:0]      f_ri;
        logic [15:0]      f_ind;
        int               f_cycles;
        logic [3:0]       f_op;
        logic [3:0]       f_carry;
        logic [3:0]       f_kind;
        logic [3:0]       f_reg;
        case_t            c;
        fd = $fopen("verif/control_unit_cases.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open the case file verif/control_unit_cases.txt");
        end
        while (!$feof(fd)) begin
            line = '0;
            n    = $fgets(line, fd);
            n    = $sscanf(line, "%h %h %d %h %h %h %h",
                f_ri, f_ind, f_cycles, f_op, f_carry, f_kind, f_reg);
            if (n == 7) begin
                c.ri        = cpu_isa_pkg::instr_t'(f_ri);
                c.ind       = cpu_isa_pkg::ind_t'(f_ind);
                c.cycles    = f_cycles[7:0];
                c.alu_op    = f_op;
                c.alu_carry = f_carry[0];
                c.wkind     = f_kind[1:0];
                c.reg_addr  = f_reg[2:0];
                cases.push_back(c);
            end else if (n > 0) begin   // Comment and blank lines give 0 or -1
                abort_run($sformatf("Malformed line in the case file after %0d cases",
                    cases.size()));
            end
        end
        $fclose(fd);
        if (cases.size() == 0) begin
            abort_run("The case file holds no cases");
        end
    endtask

    ////////////////////////////////////////
    // Per-instruction trace

    task automatic check_trace(input int idx, input case_t c);
        uc_ctrl_pkg::ctrl_word_t exec_w;
        uc_ctrl_pkg::ctrl_word_t reg_w;
        uc_ctrl_pkg::ctrl_word_t mem_w;
        uc_ctrl_pkg::ctrl_word_t cp_w;
        int                      n_exec;
        int                      n_reg;
        int                      n_mem;
        int                      n_cp;
        string                   tag;
        n_exec = 0;
        n_reg  = 0;
        n_mem  = 0;
        n_cp   = 0;
        exec_w = '0;
        reg_w  = '0;
        mem_w  = '0;
        cp_w   = '0;
        tag    = $sformatf("case %0d (ri %h)", idx, c.ri);
        foreach (trace[i]) begin
            if (trace[i].ind_we) begin      // Execute updates the flags
                n_exec++;
                exec_w = trace[i];
            end
            if (trace[i].regs_we) begin
                n_reg++;
                reg_w = trace[i];
            end
            if (trace[i].ram_we) begin
                n_mem++;
                mem_w = trace[i];
            end
            if (trace[i].cp_we) begin
                n_cp++;
                cp_w = trace[i];
            end
        end

        check_count({tag, " cycles"}, c.cycles, trace.size());
        if (c.alu_op == 4'hf) begin
            check_count({tag, " execute cycles"}, 0, n_exec);
        end else begin
            check_count({tag, " execute cycles"}, 1, n_exec);
            check_alu({tag, " execute"}, cpu_isa_pkg::alu_op_e'(c.alu_op), c.alu_carry,
                exec_w.alu_op, exec_w.alu_carry);
            if (!exec_w.ind_sel) begin
                abort_run({tag, ": the execute cycle does not take the flags from the ALU"});
            end
        end

        check_count({tag, " register writes"}, (c.wkind == 2'd1) ? 1 : 0, n_reg);
        if (c.wkind == 2'd1) begin
            check_reg({tag, " regs_addr"}, cpu_isa_pkg::reg_idx_e'(c.reg_addr),
                reg_w.regs_addr);
        end
        check_count({tag, " memory writes"}, (c.wkind == 2'd2) ? 1 : 0, n_mem);
        if (c.wkind == 2'd2 && !mem_w.am_oe) begin
            abort_run({tag, ": the memory write is not addressed through AM"});
        end

        // Either a jump target or the increment lands in CP, never both
        check_count({tag, " cp writes"}, 1, n_cp);
        if (!cp_w.alu_oe) begin
            abort_run({tag, ": the CP write does not come from the ALU"});
        end
        if (c.wkind == 2'd3) begin
            check_alu({tag, " jump"}, cpu_isa_pkg::OR, 1'b0, cp_w.alu_op, cp_w.alu_carry);
        end else begin
            check_alu({tag, " cp increment"}, cpu_isa_pkg::ADC, 1'b1,
                cp_w.alu_op, cp_w.alu_carry);
        end
    endtask

    // Entered at the negedge of FETCH0, leaves at the next FETCH0
    task automatic run_case(input int idx, input case_t c);
        bit done;
        trace.delete();
        check_ctrl($sformatf("case %0d FETCH0 ctrl", idx), fetch_word, ctrl);
        trace.push_back(ctrl);
        @(posedge clk);
        ri   <= c.ri;
        ind  <= c.ind;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);                     // Mid-cycle, outputs settled
            if (disp_state == uc_ctrl_pkg::FETCH0) begin
                done = 1'b1;
            end else begin
                trace.push_back(ctrl);
            end
        end
        check_trace(idx, c);
    endtask

    ////////////////////////////////////////
    // Main sequence

    initial begin
        clk              = 1'b0;
        rst              = 1'b0;
        ri               = '0;
        ind              = '0;
        cases_loaded     = 1'b0;
        fetch_word       = '0;
        fetch_word.cp_oe = 1'b1;                // AM <- CP only
        fetch_word.am_we = 1'b1;
        load_cases();
        cases_loaded = 1'b1;

        repeat (reset_cycles - 1) begin
            @(negedge clk);
            check_state("disp_state in reset", uc_ctrl_pkg::RESET, disp_state);
            check_ctrl("ctrl in reset", '0, ctrl);
        end
        @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        check_state("disp_state after reset release", uc_ctrl_pkg::RESET, disp_state);
        check_ctrl("ctrl after reset release", '0, ctrl);
        @(negedge clk);
        check_state("disp_state at first fetch", uc_ctrl_pkg::FETCH0, disp_state);

        foreach (cases[i]) begin
            run_case(i, cases[i]);
        end
        $display("TEST PASS");
        $finish;
    end

    // Watchdog
    initial begin
        int limit;
        wait (cases_loaded);
        limit = (cases.size() * case_budget + 10) * clk_period;
        #(limit);
        abort_run("Timeout: the run did not finish within its cycle budget");
    end

endmodule
